// File: adc_cmos_rx_config.svh
// width and latency macros for the CMOS DDR receive path, include wherever a width is needed
`ifndef ADC_CMOS_RX_CONFIG_SVH
`define ADC_CMOS_RX_CONFIG_SVH

// ********************
// converter geometry
// ********************

// one data pin per lane
`define ADC_LANES 8

// delay tap value width per lane
`define ADC_TAP_W 5

// one sample per rx_clk cycle
// upper byte on the rising edge and lower byte on the falling edge
`define ADC_SAMPLE_W 16

// ********************
// pipeline
// ********************

// lane capture takes 2 cycles
// then 1 cycle for assembly and 1 cycle for formatting
`define ADC_LATENCY 4

`endif

// File: adc_cmos_pkg.sv
// shared sample and status types for the CMOS receive path, imported with a wildcard
`default_nettype none

`include "adc_cmos_rx_config.svh"

package adc_cmos_pkg;

  // ********************
  // sample word
  // ********************

  // the same 16 bits are seen as one sample or as two captured bytes
  // the rising byte holds the upper half of the sample
  typedef union packed {
    logic [`ADC_SAMPLE_W-1:0] sample;
    struct packed {
      logic [`ADC_LANES-1:0] rise_byte;
      logic [`ADC_LANES-1:0] fall_byte;
    } bytes;
  } sample_word_u;

  // ramp monitor flags
  // oos follows the current pair, err is sticky
  typedef struct packed {
    logic oos;
    logic err;
  } mon_status_t;

endpackage

`default_nettype wire

// File: cmos_lane_in.sv
// one data lane of the converter with a loadable delay tap and a DDR capture model
`timescale 1ns/10ps
`default_nettype none

`include "adc_cmos_rx_config.svh"

module cmos_lane_in (
  input  wire                  rx_clk,
  input  wire                  reset,
  input  wire                  rx_data_in,
  input  wire                  up_dld,
  input  wire [`ADC_TAP_W-1:0] up_dwdata,
  output wire [`ADC_TAP_W-1:0] up_drdata,
  output logic                 rx_data_p,
  output logic                 rx_data_n
);

  // ********************
  // delay tap
  // ********************

  logic [`ADC_TAP_W-1:0] tap_q;
  // behavioral delay line, the tap is kept but adds no delay
  wire                   rx_data_dly;

  always_ff @(posedge rx_clk) begin
    if (reset) begin
      tap_q <= '0;
    end else if (up_dld) begin
      tap_q <= up_dwdata;
    end
  end

  // readback is continuous
  assign up_drdata   = tap_q;
  assign rx_data_dly = rx_data_in;

  // ********************
  // ddr capture
  // ********************

  logic rise_q;
  logic fall_q;
  logic n_pipe;

  // first half of the bit period
  always_ff @(posedge rx_clk) begin
    rise_q <= rx_data_dly;
  end

  // second half of the bit period
  always_ff @(negedge rx_clk) begin
    fall_q <= rx_data_dly;
  end

  // same-edge pipelined stage
  // both halves move onto the rising edge together
  always_ff @(posedge rx_clk) begin
    rx_data_p <= rise_q;
    n_pipe    <= fall_q;
  end

  // realignment register on the n path only
  // n now pairs with the p bit that followed it
  always_ff @(posedge rx_clk) begin
    rx_data_n <= n_pipe;
  end

endmodule

`default_nettype wire

// File: sample_assemble.sv
// gathers the rising and falling bytes of all lanes into one sample word with a valid level
`timescale 1ns/10ps
`default_nettype none

`include "adc_cmos_rx_config.svh"

module sample_assemble
  import adc_cmos_pkg::*;
(
  input  wire                 rx_clk,
  input  wire                 reset,
  input  wire [`ADC_LANES-1:0] lane_p,
  input  wire [`ADC_LANES-1:0] lane_n,
  output sample_word_u        asm_word,
  output logic                asm_valid
);

  // ********************
  // byte placement
  // ********************

  // lane i lands on sample bits i+8 (rising) and i (falling)
  always_ff @(posedge rx_clk) begin
    asm_word.bytes.rise_byte <= lane_p;
    asm_word.bytes.fall_byte <= lane_n;
  end

  // ********************
  // pipeline fill
  // ********************

  // counts edges after reset until the capture stages hold real data
  logic [1:0] fill_cnt;

  always_ff @(posedge rx_clk) begin
    if (reset) begin
      fill_cnt  <= 2'd0;
      asm_valid <= 1'b0;
    end else if (!asm_valid) begin
      fill_cnt <= fill_cnt + 2'd1;
      // second edge after release
      if (fill_cnt == 2'd1) begin
        asm_valid <= 1'b1;
      end
    end
  end

  // the converter streams without gaps
  // so valid stays high until the next reset

endmodule

`default_nettype wire

// File: data_format.sv
// converts assembled samples from offset binary to two's complement when enabled
`timescale 1ns/10ps
`default_nettype none

`include "adc_cmos_rx_config.svh"

module data_format
  import adc_cmos_pkg::*;
(
  input  wire                      rx_clk,
  input  wire                      reset,
  input  sample_word_u             asm_word,
  input  wire                      asm_valid,
  input  wire                      fmt_twos,
  output logic [`ADC_SAMPLE_W-1:0] adc_data,
  output logic                     adc_valid
);

  // ********************
  // format select
  // ********************

  logic [`ADC_SAMPLE_W-1:0] raw_sample;
  logic [`ADC_SAMPLE_W-1:0] twos_sample;
  logic [`ADC_SAMPLE_W-1:0] fmt_sample;

  // whole-sample view of the assembled word
  assign raw_sample = asm_word.sample;

  // offset binary to two's complement
  // flipping the msb moves mid-scale to zero
  assign twos_sample = {~raw_sample[`ADC_SAMPLE_W-1], raw_sample[`ADC_SAMPLE_W-2:0]};

  assign fmt_sample = fmt_twos ? twos_sample : raw_sample;

  // ********************
  // output register
  // ********************

  always_ff @(posedge rx_clk) begin
    adc_data <= fmt_sample;
  end

  // valid follows the assembly stage by one cycle
  always_ff @(posedge rx_clk) begin
    if (reset) begin
      adc_valid <= 1'b0;
    end else begin
      adc_valid <= asm_valid;
    end
  end

endmodule

`default_nettype wire

// File: ramp_monitor.sv
// checks the converter test ramp on the output samples and reports sync and error flags
`timescale 1ns/10ps
`default_nettype none

`include "adc_cmos_rx_config.svh"

module ramp_monitor
  import adc_cmos_pkg::*;
(
  input  wire                      rx_clk,
  input  wire                      reset,
  input  wire [`ADC_SAMPLE_W-1:0]  adc_data,
  input  wire                      adc_valid,
  input  wire                      mon_enable,
  output mon_status_t              adc_status
);

  // ********************
  // expected value
  // ********************

  logic [`ADC_SAMPLE_W-1:0] prev_sample;
  logic [`ADC_SAMPLE_W-1:0] next_expect;
  logic                     primed;
  logic                     ramp_break;

  // ramp step of one, wraps at full scale
  assign next_expect = prev_sample + 1'b1;
  assign ramp_break  = (adc_data != next_expect);

  // every valid sample becomes the reference for the next one
  always_ff @(posedge rx_clk) begin
    if (adc_valid) begin
      prev_sample <= adc_data;
    end
  end

  // ********************
  // status flags
  // ********************

  always_ff @(posedge rx_clk) begin
    if (reset) begin
      primed     <= 1'b0;
      adc_status <= '0;
    end else if (!mon_enable) begin
      // disabled monitor drops history and clears both flags
      primed     <= 1'b0;
      adc_status <= '0;
    end else if (adc_valid) begin
      // first sample after enable only primes the reference
      primed <= 1'b1;
      if (primed) begin
        adc_status.oos <= ramp_break;
        if (ramp_break) begin
          adc_status.err <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: adc_cmos_rx.sv
// top level of the CMOS DDR receive path, builds the lanes and chains assembly, format and monitor
`timescale 1ns/10ps
`default_nettype none

`include "adc_cmos_rx_config.svh"

module adc_cmos_rx
  import adc_cmos_pkg::*;
(
  input  wire                                rx_clk,
  input  wire                                reset,
  input  wire [`ADC_LANES-1:0]               rx_data_in,
  input  wire [`ADC_LANES-1:0]               up_dld,
  input  wire [`ADC_TAP_W-1:0]               up_dwdata,
  input  wire                                fmt_twos,
  input  wire                                mon_enable,
  output wire [`ADC_LANES*`ADC_TAP_W-1:0]    up_drdata,
  output wire [`ADC_SAMPLE_W-1:0]            adc_data,
  output wire                                adc_valid,
  output mon_status_t                        adc_status
);

  // ********************
  // capture
  // ********************

  wire [`ADC_LANES-1:0] lane_p;
  wire [`ADC_LANES-1:0] lane_n;

  // one lane per pin, taps share the write bus and load by their own strobe
  genvar i;
  generate
    for (i = 0; i < `ADC_LANES; i = i + 1) begin : g_lane
      cmos_lane_in i_lane (
        .rx_clk     (rx_clk),
        .reset      (reset),
        .rx_data_in (rx_data_in[i]),
        .up_dld     (up_dld[i]),
        .up_dwdata  (up_dwdata),
        .up_drdata  (up_drdata[i*`ADC_TAP_W +: `ADC_TAP_W]),
        .rx_data_p  (lane_p[i]),
        .rx_data_n  (lane_n[i])
      );
    end
  endgenerate

  // ********************
  // assembly and format
  // ********************

  sample_word_u asm_word;
  wire          asm_valid;

  sample_assemble i_assemble (
    .rx_clk    (rx_clk),
    .reset     (reset),
    .lane_p    (lane_p),
    .lane_n    (lane_n),
    .asm_word  (asm_word),
    .asm_valid (asm_valid)
  );

  data_format i_format (
    .rx_clk    (rx_clk),
    .reset     (reset),
    .asm_word  (asm_word),
    .asm_valid (asm_valid),
    .fmt_twos  (fmt_twos),
    .adc_data  (adc_data),
    .adc_valid (adc_valid)
  );

  // monitor watches the same samples that leave the core
  ramp_monitor i_monitor (
    .rx_clk     (rx_clk),
    .reset      (reset),
    .adc_data   (adc_data),
    .adc_valid  (adc_valid),
    .mon_enable (mon_enable),
    .adc_status (adc_status)
  );

endmodule

`default_nettype wire

// File: tb_adc_cmos_rx.sv
// testbench for the CMOS DDR receive path, run as the simulation top through the file list
`timescale 1ns/10ps
`default_nettype none

`include "adc_cmos_rx_config.svh"

module tb_adc_cmos_rx
  import adc_cmos_pkg::*;
();

  localparam int clk_half = 10;
  localparam int num_entries = 10;
  // fmt_twos is sampled by the format register one edge before the sample shows
  localparam int fmt_lag = `ADC_LATENCY - 1;
  localparam int watchdog_cycles = num_entries + 64;
  localparam logic [`ADC_LANES-1:0] pad_byte = 8'h00;

  logic                              rx_clk;
  logic                              reset;
  logic [`ADC_LANES-1:0]             rx_data_in;
  logic [`ADC_LANES-1:0]             up_dld;
  logic [`ADC_TAP_W-1:0]             up_dwdata;
  logic                              fmt_twos;
  logic                              mon_enable;
  wire  [`ADC_LANES*`ADC_TAP_W-1:0]  up_drdata;
  wire  [`ADC_SAMPLE_W-1:0]          adc_data;
  wire                               adc_valid;
  mon_status_t                       adc_status;

  // stimulus table, one entry per driven lane byte
  string                    tname [num_entries];
  logic [`ADC_LANES-1:0]    tbyte [num_entries];
  logic                     tfmt  [num_entries];
  logic [`ADC_SAMPLE_W-1:0] texp  [num_entries];

  // tap values the lanes should hold
  logic [`ADC_TAP_W-1:0]    exp_tap [`ADC_LANES];

  integer seed;
  int     errors;
  int     checks;

  adc_cmos_rx dut (
    .rx_clk     (rx_clk),
    .reset      (reset),
    .rx_data_in (rx_data_in),
    .up_dld     (up_dld),
    .up_dwdata  (up_dwdata),
    .fmt_twos   (fmt_twos),
    .mon_enable (mon_enable),
    .up_drdata  (up_drdata),
    .adc_data   (adc_data),
    .adc_valid  (adc_valid),
    .adc_status (adc_status)
  );

  // ********************
  // helpers
  // ********************

  task automatic set_entry(input int idx, input string name,
                           input logic [`ADC_LANES-1:0] lane_byte, input logic fmt,
                           input logic [`ADC_SAMPLE_W-1:0] expect_data);
    tname[idx] = name;
    tbyte[idx] = lane_byte;
    tfmt[idx]  = fmt;
    texp[idx]  = expect_data;
  endtask

  // both bytes of the sample carry the entry's own byte
  // fmt high flips bit 15
  task automatic fill_table();
    set_entry(0, "place_00", 8'h00, 1'b0, 16'h0000);
    set_entry(1, "place_ff", 8'hff, 1'b0, 16'hffff);
    set_entry(2, "place_a5", 8'ha5, 1'b0, 16'ha5a5);
    set_entry(3, "place_lane0", 8'h01, 1'b0, 16'h0101);
    set_entry(4, "place_lane7", 8'h80, 1'b0, 16'h8080);
    set_entry(5, "twos_00", 8'h00, 1'b1, 16'h8000);
    set_entry(6, "twos_ff", 8'hff, 1'b1, 16'h7fff);
    set_entry(7, "twos_5a", 8'h5a, 1'b1, 16'hda5a);
    set_entry(8, "twos_80", 8'h80, 1'b1, 16'h0080);
    set_entry(9, "offset_3c", 8'h3c, 1'b0, 16'h3c3c);
  endtask

  function automatic logic [`ADC_LANES*`ADC_TAP_W-1:0] expected_taps();
    logic [`ADC_LANES*`ADC_TAP_W-1:0] v;
    v = '0;
    for (int i = 0; i < `ADC_LANES; i++) begin
      v[i*`ADC_TAP_W +: `ADC_TAP_W] = exp_tap[i];
    end
    return v;
  endfunction

  task automatic compare_value(input string name, input logic [39:0] expected,
                               input logic [39:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch %s expected 0x%0h actual 0x%0h", name, expected, actual);
    end
  endtask

  // ********************
  // clock and watchdog
  // ********************

  initial begin
    rx_clk = 1'b0;
    forever #(clk_half) rx_clk = ~rx_clk;
  end

  initial begin
    #(watchdog_cycles * 2 * clk_half);
    $display("Error: watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    $display("TB FAILED");
    $finish;
  end

  // ********************
  // main sequence
  // ********************

  initial begin
    int                    j;
    int                    wait_cnt;
    logic [31:0]           rnd;
    logic [`ADC_TAP_W-1:0] tap;
    logic [`ADC_LANES-1:0] one_hot;
    seed       = 32'ha345;
    errors     = 0;
    checks     = 0;
    reset      = 1'b1;
    rx_data_in = '0;
    up_dld     = '0;
    up_dwdata  = '0;
    fmt_twos   = 1'b0;
    mon_enable = 1'b0;
    fill_table();
    for (int i = 0; i < `ADC_LANES; i++) begin
      exp_tap[i] = '0;
    end

    // reset state, seen before release
    repeat (7) @(posedge rx_clk);
    @(negedge rx_clk);
    compare_value("reset_valid", 40'(1'b0), 40'(adc_valid));
    compare_value("reset_status", 40'(2'b00), 40'(adc_status));
    compare_value("reset_taps", 40'd0, up_drdata);
    @(posedge rx_clk);
    reset <= 1'b0;

    // valid rises once the pipeline has filled
    wait_cnt = 0;
    while (adc_valid !== 1'b1 && wait_cnt < 8) begin
      @(negedge rx_clk);
      wait_cnt++;
    end
    checks++;
    if (adc_valid !== 1'b1) begin
      errors++;
      $display("Error: adc_valid did not rise within 8 cycles after reset release");
    end

    // one strobe per lane, readback one edge later
    for (int i = 0; i < `ADC_LANES; i++) begin
      rnd = $random(seed);
      tap = rnd[`ADC_TAP_W-1:0];
      one_hot = '0;
      one_hot[i] = 1'b1;
      @(posedge rx_clk);
      up_dld     <= one_hot;
      up_dwdata  <= tap;
      exp_tap[i] = tap;
      @(posedge rx_clk);
      up_dld <= '0;
      @(negedge rx_clk);
      compare_value($sformatf("tap_lane%0d", i), expected_taps(), up_drdata);
    end

    // table stream
    // fmt_twos is driven so that it meets the sample at the format register
    for (int c = 0; c < num_entries + `ADC_LATENCY; c++) begin
      @(posedge rx_clk);
      rx_data_in <= (c < num_entries) ? tbyte[c] : pad_byte;
      j = c - fmt_lag;
      if (j >= 0 && j < num_entries) begin
        fmt_twos <= tfmt[j];
      end else begin
        fmt_twos <= 1'b0;
      end
      @(negedge rx_clk);
      compare_value("stream_valid", 40'(1'b1), 40'(adc_valid));
      compare_value("stream_status", 40'(2'b00), 40'(adc_status));
      j = c - `ADC_LATENCY;
      if (j >= 0) begin
        compare_value(tname[j], 40'(texp[j]), 40'(adc_data));
      end
    end

    // constant data breaks the ramp
    @(posedge rx_clk);
    rx_data_in <= 8'h5a;
    mon_enable <= 1'b1;
    wait_cnt = 0;
    @(negedge rx_clk);
    while (!(adc_status.oos === 1'b1 && adc_status.err === 1'b1) && wait_cnt < 12) begin
      @(negedge rx_clk);
      wait_cnt++;
    end
    checks++;
    if (!(adc_status.oos === 1'b1 && adc_status.err === 1'b1)) begin
      errors++;
      $display("Error: ramp monitor did not flag a constant stream within 12 cycles");
    end

    // full scale followed by zero is one matching pair
    // oos drops for that pair while err stays set
    @(posedge rx_clk);
    rx_data_in <= 8'hff;
    @(posedge rx_clk);
    @(posedge rx_clk);
    rx_data_in <= 8'h00;
    repeat (`ADC_LATENCY + 1) @(posedge rx_clk);
    @(negedge rx_clk);
    compare_value("mon_oos_clear", 40'(1'b0), 40'(adc_status.oos));
    compare_value("mon_err_hold", 40'(1'b1), 40'(adc_status.err));

    // disabling the monitor clears err
    @(posedge rx_clk);
    mon_enable <= 1'b0;
    @(posedge rx_clk);
    @(negedge rx_clk);
    compare_value("mon_disable", 40'(2'b00), 40'(adc_status));

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: adc_cmos_rx.f
+incdir+.
adc_cmos_pkg.sv
cmos_lane_in.sv
sample_assemble.sv
data_format.sv
ramp_monitor.sv
adc_cmos_rx.sv
tb_adc_cmos_rx.sv

// File: run_sim.sh
#!/bin/sh
# compile the receive path testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f adc_cmos_rx.f --top-module tb_adc_cmos_rx

sim_out=$(./obj_dir/Vtb_adc_cmos_rx)
echo "$sim_out"

if echo "$sim_out" | grep -q "TB PASSED"; then
  exit 0
fi
exit 1
